//--- Makefile
# Verilator build for the double-buffered display core

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_vga_top
LINT_TOP  ?= vga_top
BUILD_DIR ?= obj_dir
JOBS      ?= 0
PASS_MSG  ?= No errors

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module $(LINT_TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- draw_ctrl.sv
`default_nettype none

module draw_ctrl
    import video_pkg::*;
#(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      draw_valid,
    input  draw_cmd_t draw_cmd,
    input  logic      clear_valid,
    input  color_t    clear_color,
    input  buf_sel_t  front_sel,
    output logic      busy,
    output fb_write_t wr
);

    localparam int DEPTH = FB_WIDTH * FB_HEIGHT;

    draw_state_t state;
    fb_addr_t    clr_addr;
    color_t      clr_color;

    logic     in_range;
    fb_addr_t pix_addr;

    assign in_range = (draw_cmd.x < coord_t'(FB_WIDTH)) && (draw_cmd.y < coord_t'(FB_HEIGHT));

    assign pix_addr = fb_addr_t'(draw_cmd.y) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(draw_cmd.x);

    assign busy = (state == CLEAR);

    //////////////////////////////////////////////////
    // Command handling and clear sweep
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            wr.en  <= 1'b0;
        end else begin
            wr.en <= 1'b0;
            case (state)
                IDLE: begin
                    // Clear wins over a pixel in the same cycle
                    if (clear_valid) begin
                        state <= CLEAR;
                    end else if (draw_valid && in_range) begin
                        wr.en <= 1'b1;
                    end
                end
                CLEAR: begin
                    wr.en <= 1'b1;
                    if (clr_addr == fb_addr_t'(DEPTH - 1)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Write payload and sweep counter
    always_ff @(posedge clk) begin
        wr.sel <= ~front_sel;
        if (state == IDLE) begin
            clr_addr  <= '0;
            clr_color <= clear_color;
            wr.addr   <= pix_addr;
            wr.data   <= draw_cmd.color;
        end else begin
            clr_addr <= clr_addr + 1'b1;
            wr.addr  <= clr_addr;
            wr.data  <= clr_color;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
video_pkg.sv
video_timing.sv
frame_buffer.sv
draw_ctrl.sv
scanout.sv
vga_top.sv
tb_vga_top.sv

//--- frame_buffer.sv
`default_nettype none

module frame_buffer
    import video_pkg::*;
#(
    parameter int DEPTH     = 192,
    parameter int BUF_INDEX = 0
) (
    input  logic      clk,
    input  fb_write_t wr,
    input  fb_addr_t  rd_addr,
    output color_t    rd_data
);

    localparam int AW = $clog2(DEPTH);

    color_t mem [0:DEPTH-1];

    logic wr_hit;

    // Only the buffer named by sel takes the write
    assign wr_hit = wr.en && (wr.sel == buf_sel_t'(BUF_INDEX));

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem[wr.addr[AW-1:0]] <= wr.data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[AW-1:0]];
    end

endmodule

`default_nettype wire

//--- scanout.sv
`default_nettype none

module scanout
    import video_pkg::*;
#(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 3,
    parameter int H_BACK    = 3,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     swap_req,
    input  color_t [NUM_BUFFERS-1:0] rd_data,
    output fb_addr_t                 rd_addr,
    output buf_sel_t                 front_sel,
    output logic                     frame_swapped,
    output vga_out_t                 vga
);

    coord_t h_pos;
    coord_t v_pos;
    logic   active;
    logic   hsync;
    logic   vsync;
    logic   blank_start;

    logic active_d;
    logic hsync_d;
    logic vsync_d;
    logic swap_pending;

    video_timing #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK)
    ) video_timing_inst (
        .clk(clk),
        .rst(rst),
        .h_pos(h_pos),
        .v_pos(v_pos),
        .active(active),
        .hsync(hsync),
        .vsync(vsync),
        .blank_start(blank_start)
    );

    // Address parks at zero outside the active area
    assign rd_addr = active ? fb_addr_t'(v_pos) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(h_pos) : '0;

    //////////////////////////////////////////////////
    // Pixel pipeline, RAM read then output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
            vga      <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, color: '0};
        end else begin
            active_d  <= active;
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            vga.hsync <= hsync_d;
            vga.vsync <= vsync_d;
            vga.de    <= active_d;
            vga.color <= active_d ? rd_data[front_sel] : '0;
        end
    end

    //////////////////////////////////////////////////
    // Buffer swap at start of vertical blanking
    //////////////////////////////////////////////////

    assign frame_swapped = blank_start && swap_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            front_sel    <= 1'b0;
            swap_pending <= 1'b0;
        end else if (frame_swapped) begin
            front_sel    <= ~front_sel;
            // A request in the swap cycle arms the next one
            swap_pending <= swap_req;
        end else if (swap_req) begin
            swap_pending <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tb_vga_top.sv
`default_nettype none

module tb_vga_top
    import video_pkg::*;
();

    localparam int FB_W         = 16;
    localparam int FB_H         = 12;
    localparam int DEPTH        = FB_W * FB_H;
    localparam int H_TOTAL      = 24;
    localparam int V_TOTAL      = 16;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // All tests together take about 22 frames
    localparam int MAX_CYCLES   = 40 * FRAME_CYCLES;

    logic      clk;
    logic      rst;
    logic      draw_valid;
    draw_cmd_t draw_cmd;
    logic      clear_valid;
    color_t    clear_color;
    logic      swap_req;
    logic      busy;
    logic      frame_swapped;
    vga_out_t  vga;

    int       seed;
    int       errors;
    int       tests_run;
    int       tests_failed;
    int       cycles;
    int       err_start;
    color_t   fill;

    // Reference model, two images and the front index
    color_t   model_mem [0:1][0:DEPTH-1];
    logic     known [0:1];
    buf_sel_t model_front;
    int       clear_left;
    int       busy_cycles;
    logic     swapped_now;

    // Output monitor state
    int       pix_idx;
    int       pix_checked;
    int       frames;
    int       frame_de;
    int       de_run;
    int       hs_run;
    int       vs_run;
    int       hs_count;
    logic     prev_vs;
    logic     frame_armed;
    // Buffer that the frame on screen is read from
    buf_sel_t shown_front;

    vga_top #(
        .FB_WIDTH(FB_W),
        .FB_HEIGHT(FB_H)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .draw_valid(draw_valid),
        .draw_cmd(draw_cmd),
        .clear_valid(clear_valid),
        .clear_color(clear_color),
        .swap_req(swap_req),
        .busy(busy),
        .frame_swapped(frame_swapped),
        .vga(vga)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // Raster format and frame checker
    //////////////////////////////////////////////////

    task monitor_outputs();
        if (prev_vs && !vga.vsync) begin
            if (frame_armed) begin
                check(32'(frame_de), 32'(DEPTH), "de cycles per frame");
                check(32'(hs_count), 32'(V_TOTAL), "hsync pulses per frame");
            end
            frame_armed = 1'b1;
            frames++;
            frame_de = 0;
            hs_count = 0;
            pix_idx = 0;
            // The swap lands in blanking, so the new front shows from here on
            shown_front = model_front;
        end
        prev_vs = vga.vsync;
        if (vga.de) begin
            frame_de++;
            de_run++;
            if (known[shown_front] && pix_idx < DEPTH) begin
                check(32'(vga.color), 32'(model_mem[shown_front][pix_idx]),
                      $sformatf("color of pixel %0d", pix_idx));
                pix_checked++;
            end
            pix_idx++;
        end else begin
            check(32'(vga.color), 32'h0, "color outside the active area");
            if (de_run != 0) begin
                check(32'(de_run), 32'(FB_W), "de cycles per line");
            end
            de_run = 0;
        end
        if (!vga.hsync) begin
            hs_run++;
        end else if (hs_run != 0) begin
            check(32'(hs_run), 32'd3, "hsync low length");
            hs_run = 0;
            hs_count++;
        end
        if (!vga.vsync) begin
            vs_run++;
        end else if (vs_run != 0) begin
            check(32'(vs_run), 32'(2 * H_TOTAL), "vsync low length");
            vs_run = 0;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus, one call per clock
    //////////////////////////////////////////////////

    task drive_cycle(input logic dv, input draw_cmd_t cmd, input logic cv,
                     input color_t cc, input logic sw);
        buf_sel_t back;
        int       i;
        @(negedge clk);
        monitor_outputs();
        swapped_now = frame_swapped;
        if (frame_swapped) begin
            model_front = ~model_front;
        end
        if (busy) begin
            busy_cycles++;
        end
        back = ~model_front;
        draw_valid = dv;
        draw_cmd = cmd;
        clear_valid = cv;
        clear_color = cc;
        swap_req = sw;
        // Strobes are dropped while a clear runs, and a clear wins over a pixel
        if (clear_left > 0) begin
            clear_left--;
        end else if (cv) begin
            for (i = 0; i < DEPTH; i++) begin
                model_mem[back][i] = cc;
            end
            known[back] = 1'b1;
            clear_left = DEPTH;
        end else if (dv && cmd.x < coord_t'(FB_W) && cmd.y < coord_t'(FB_H)) begin
            i = int'(cmd.y) * FB_W + int'(cmd.x);
            model_mem[back][i] = cmd.color;
        end
    endtask

    task idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, 1'b0);
    endtask

    task wait_frames(input int n);
        int target;
        target = frames + n;
        while (frames < target) begin
            idle_cycles(1);
        end
    endtask

    // Swap, then compare one whole frame from the new front buffer
    task swap_and_show();
        int start;
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b1);
        idle_cycles(1);
        while (!swapped_now) begin
            idle_cycles(1);
        end
        start = pix_checked;
        wait_frames(2);
        check(32'(pix_checked - start >= DEPTH), 32'd1, "full frame compared after swap");
    endtask

    task clear_back(input color_t c);
        busy_cycles = 0;
        drive_cycle(1'b0, '0, 1'b1, c, 1'b0);
        idle_cycles(1);
        while (busy) begin
            idle_cycles(1);
        end
        check(32'(busy_cycles), 32'(DEPTH), "busy cycles of a clear");
    endtask

    function automatic draw_cmd_t random_pixel();
        draw_cmd_t cmd;
        cmd.x = coord_t'($unsigned($random(seed)) % FB_W);
        cmd.y = coord_t'($unsigned($random(seed)) % FB_H);
        cmd.color = color_t'($random(seed));
        return cmd;
    endfunction

    function automatic draw_cmd_t random_outside();
        draw_cmd_t cmd;
        cmd = random_pixel();
        if ($random(seed) & 1) begin
            cmd.x = coord_t'(FB_W + $unsigned($random(seed)) % (256 - FB_W));
        end else begin
            cmd.y = coord_t'(FB_H + $unsigned($random(seed)) % (256 - FB_H));
        end
        return cmd;
    endfunction

    task report_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s, %0d check failures", name, errors - start);
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        draw_valid = 1'b0;
        draw_cmd = '0;
        clear_valid = 1'b0;
        clear_color = '0;
        swap_req = 1'b0;
        seed = 32'h6c0ad3df;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        clear_left = 0;
        busy_cycles = 0;
        pix_idx = 0;
        pix_checked = 0;
        frames = 0;
        frame_de = 0;
        de_run = 0;
        hs_run = 0;
        vs_run = 0;
        hs_count = 0;
        known[0] = 1'b0;
        known[1] = 1'b0;
        model_front = 1'b0;
        shown_front = 1'b0;
        swapped_now = 1'b0;
        prev_vs = 1'b1;
        frame_armed = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err_start = errors;
        wait_frames(3);
        report_test("raster format", err_start);

        err_start = errors;
        fill = color_t'($random(seed));
        clear_back(fill);
        swap_and_show();
        report_test("clear then swap", err_start);

        err_start = errors;
        clear_back(color_t'($random(seed)));
        repeat (40) begin
            drive_cycle(1'b1, random_pixel(), 1'b0, '0, 1'b0);
            idle_cycles(1);
        end
        swap_and_show();
        report_test("random pixel writes", err_start);

        err_start = errors;
        repeat (20) drive_cycle(1'b1, random_pixel(), 1'b0, '0, 1'b0);
        wait_frames(3);
        report_test("isolation and no tearing", err_start);

        err_start = errors;
        swap_and_show();
        swap_and_show();
        report_test("role exchange", err_start);

        // Pixel and clear strobes inside a running clear are all dropped
        err_start = errors;
        busy_cycles = 0;
        drive_cycle(1'b1, random_pixel(), 1'b1, color_t'($random(seed)), 1'b0);
        repeat (100) begin
            drive_cycle(1'b1, random_pixel(), 1'($random(seed)), color_t'($random(seed)), 1'b0);
        end
        while (busy) begin
            idle_cycles(1);
        end
        check(32'(busy_cycles), 32'(DEPTH), "busy cycles with strobes during a clear");
        repeat (20) drive_cycle(1'b1, random_outside(), 1'b0, '0, 1'b0);
        swap_and_show();
        report_test("rejected commands", err_start);

        $display("Summary: %0d tests run, %0d failed, %0d check failures",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vga_top.sv
`default_nettype none

module vga_top
    import video_pkg::*;
#(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 3,
    parameter int H_BACK    = 3,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      draw_valid,
    input  draw_cmd_t draw_cmd,
    input  logic      clear_valid,
    input  color_t    clear_color,
    input  logic      swap_req,
    output logic      busy,
    output logic      frame_swapped,
    output vga_out_t  vga
);

    fb_write_t                wr;
    fb_addr_t                 rd_addr;
    color_t [NUM_BUFFERS-1:0] rd_data;
    buf_sel_t                 front_sel;

    //////////////////////////////////////////////////
    // Drawing, always into the back buffer
    //////////////////////////////////////////////////

    draw_ctrl #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) draw_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .draw_valid(draw_valid),
        .draw_cmd(draw_cmd),
        .clear_valid(clear_valid),
        .clear_color(clear_color),
        .front_sel(front_sel),
        .busy(busy),
        .wr(wr)
    );

    //////////////////////////////////////////////////
    // Frame buffers
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_BUFFERS; i++) begin : g_fb
        frame_buffer #(
            .DEPTH(FB_WIDTH * FB_HEIGHT),
            .BUF_INDEX(i)
        ) frame_buffer_inst (
            .clk(clk),
            .wr(wr),
            .rd_addr(rd_addr),
            .rd_data(rd_data[i])
        );
    end

    //////////////////////////////////////////////////
    // Display
    //////////////////////////////////////////////////

    scanout #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK)
    ) scanout_inst (
        .clk(clk),
        .rst(rst),
        .swap_req(swap_req),
        .rd_data(rd_data),
        .rd_addr(rd_addr),
        .front_sel(front_sel),
        .frame_swapped(frame_swapped),
        .vga(vga)
    );

endmodule

`default_nettype wire

//--- video_pkg.sv
`default_nettype none

package video_pkg;

    //////////////////////////////////////////////////
    // Basic widths
    //////////////////////////////////////////////////

    // Red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] color_t;

    // Raster or buffer position along one axis
    typedef logic [7:0] coord_t;

    // Linear buffer address, y * width + x
    typedef logic [15:0] fb_addr_t;

    // Index of one frame buffer
    typedef logic buf_sel_t;

    // Double buffering
    localparam int NUM_BUFFERS = 2;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        coord_t x;
        coord_t y;
        color_t color;
    } draw_cmd_t;

    // One write, broadcast to all buffers
    typedef struct packed {
        logic     en;
        buf_sel_t sel;
        fb_addr_t addr;
        color_t   data;
    } fb_write_t;

    // Syncs are active low
    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        color_t color;
    } vga_out_t;

    typedef enum logic {
        IDLE,
        CLEAR
    } draw_state_t;

endpackage

`default_nettype wire

//--- video_timing.sv
`default_nettype none

module video_timing
    import video_pkg::*;
#(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 3,
    parameter int H_BACK    = 3,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  logic   clk,
    input  logic   rst,
    output coord_t h_pos,
    output coord_t v_pos,
    output logic   active,
    output logic   hsync,
    output logic   vsync,
    output logic   blank_start
);

    localparam int H_TOTAL = FB_WIDTH + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = FB_HEIGHT + V_FRONT + V_SYNC + V_BACK;

    // Sync pulse windows
    localparam int HS_START = FB_WIDTH + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = FB_HEIGHT + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    //////////////////////////////////////////////////
    // Raster counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            h_pos <= '0;
            v_pos <= '0;
        end else if (h_pos == coord_t'(H_TOTAL - 1)) begin
            h_pos <= '0;
            if (v_pos == coord_t'(V_TOTAL - 1)) begin
                v_pos <= '0;
            end else begin
                v_pos <= v_pos + 1'b1;
            end
        end else begin
            h_pos <= h_pos + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    assign active = (h_pos < coord_t'(FB_WIDTH)) && (v_pos < coord_t'(FB_HEIGHT));

    assign hsync = !((h_pos >= coord_t'(HS_START)) && (h_pos < coord_t'(HS_END)));
    assign vsync = !((v_pos >= coord_t'(VS_START)) && (v_pos < coord_t'(VS_END)));

    // First cycle of the first blank line
    assign blank_start = (h_pos == '0) && (v_pos == coord_t'(FB_HEIGHT));

endmodule

`default_nettype wire
